/* common/post_hash_pkg.sv */
package post_hash_pkg;

  localparam int num_hash_pe      = 4;
  localparam int hash_issue_width = 4;
  localparam int row_size         = 2;
  localparam int addr_width       = 16;
  localparam int meta_len_width   = 5;
  localparam int lane_idx_width   = $clog2(hash_issue_width);

  // one entry of a hash table row as seen by a hash PE.
  typedef struct packed {
    logic                      valid;
    logic [addr_width-1:0]     hist_addr;
    logic [meta_len_width-1:0] meta_len;
    logic                      can_ext;
  } cand_t;

  typedef struct packed {
    logic [addr_width-1:0]   head_addr;
    cand_t [row_size-1:0]    row;
    logic                    delim;
    logic [7:0]              data;
  } pe_result_t;

  typedef struct packed {
    logic [num_hash_pe-1:0]       mask;
    pe_result_t [num_hash_pe-1:0] pe;
  } pe_beat_t;

  // the chosen candidate of one byte position plus its context.
  typedef struct packed {
    logic                      hist_valid;
    logic [addr_width-1:0]     hist_addr;
    logic [meta_len_width-1:0] meta_len;
    logic                      can_ext;
    logic                      delim;
    logic [7:0]                data;
  } lane_t;

  typedef struct packed {
    logic [num_hash_pe-1:0]                 mask;
    logic [num_hash_pe-1:0][addr_width-1:0] head_addr;
    lane_t [num_hash_pe-1:0]                lane;
  } merged_beat_t;

  typedef struct packed {
    logic [addr_width-1:0]       head_addr;
    logic [hash_issue_width-1:0] row_valid;
    lane_t [hash_issue_width-1:0] lane;
  } row_beat_t;

  // lane delim bits are always zero here because the row flag carries it.
  typedef struct packed {
    logic [addr_width-1:0]        head_addr;
    lane_t [hash_issue_width-1:0] lane;
    logic                         delim;
  } issue_row_t;

endpackage

/* rtl/hash_row_merge.sv */
`timescale 1ns/10ps

module hash_row_merge (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        in_valid,
  input  post_hash_pkg::pe_beat_t     in_beat,
  output logic                        in_ready,

  output logic                        out_valid,
  output post_hash_pkg::merged_beat_t out_beat,
  input  logic                        out_ready
);

  post_hash_pkg::merged_beat_t merged;

  // the longest valid candidate wins and the strict compare keeps the lower index on a tie.
  function automatic post_hash_pkg::lane_t pick_best(
    input post_hash_pkg::pe_result_t pe
  );
    post_hash_pkg::lane_t best;
    best = '0;
    for (int j = 0; j < post_hash_pkg::row_size; j++) begin
      if (pe.row[j].valid && (!best.hist_valid || pe.row[j].meta_len > best.meta_len)) begin
        best.hist_valid = 1'b1;
        best.hist_addr  = pe.row[j].hist_addr;
        best.meta_len   = pe.row[j].meta_len;
        best.can_ext    = pe.row[j].can_ext;
      end
    end
    best.delim = pe.delim;
    best.data  = pe.data;
    return best;
  endfunction

  always_comb begin
    merged.mask = in_beat.mask;
    for (int i = 0; i < post_hash_pkg::num_hash_pe; i++) begin
      merged.head_addr[i] = in_beat.pe[i].head_addr;
      merged.lane[i]      = pick_best(in_beat.pe[i]);
    end
  end

  // the stage accepts when its register is empty or drains this cycle.
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_beat <= merged;
    end
  end

endmodule

/* rtl/reorder_crossbar.sv */
`timescale 1ns/10ps

module reorder_crossbar (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        in_valid,
  input  post_hash_pkg::merged_beat_t in_beat,
  output logic                        in_ready,

  output logic                        out_valid,
  output post_hash_pkg::row_beat_t    out_row,
  input  logic                        out_ready
);

  post_hash_pkg::row_beat_t            routed;
  logic [post_hash_pkg::lane_idx_width-1:0] lane_idx;

  // every masked PE lies in the same aligned window, so any of them gives the base.
  always_comb begin
    routed   = '0;
    lane_idx = '0;
    for (int i = 0; i < post_hash_pkg::num_hash_pe; i++) begin
      if (in_beat.mask[i]) begin
        lane_idx                  = in_beat.head_addr[i][post_hash_pkg::lane_idx_width-1:0];
        routed.lane[lane_idx]      = in_beat.lane[i];
        routed.row_valid[lane_idx] = 1'b1;
        routed.head_addr = {
          in_beat.head_addr[i][post_hash_pkg::addr_width-1:post_hash_pkg::lane_idx_width],
          {post_hash_pkg::lane_idx_width{1'b0}}
        };
      end
    end
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_row <= routed;
    end
  end

endmodule

/* rtl/hash_row_synchronizer.sv */
`timescale 1ns/10ps

module hash_row_synchronizer (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        in_valid,
  input  post_hash_pkg::row_beat_t    in_row,
  output logic                        in_ready,

  output logic                        out_valid,
  output post_hash_pkg::issue_row_t   out_row,
  input  logic                        out_ready
);

  logic [post_hash_pkg::hash_issue_width-1:0]  acc_mask;
  logic                                        acc_delim;
  post_hash_pkg::lane_t [post_hash_pkg::hash_issue_width-1:0] acc_lane;

  logic [post_hash_pkg::hash_issue_width-1:0]  next_mask;
  logic                                        next_delim;
  post_hash_pkg::lane_t [post_hash_pkg::hash_issue_width-1:0] next_lane;
  post_hash_pkg::issue_row_t                   done_row;
  logic                                        in_fire;
  logic                                        row_done;

  always_comb begin
    next_mask  = acc_mask | in_row.row_valid;
    next_delim = acc_delim;
    next_lane  = acc_lane;
    for (int k = 0; k < post_hash_pkg::hash_issue_width; k++) begin
      if (in_row.row_valid[k]) begin
        next_lane[k] = in_row.lane[k];
        next_delim   = next_delim | in_row.lane[k].delim;
      end
    end
  end

  always_comb begin
    done_row.head_addr = in_row.head_addr;
    done_row.delim     = next_delim;
    for (int k = 0; k < post_hash_pkg::hash_issue_width; k++) begin
      done_row.lane[k]       = next_lane[k];
      done_row.lane[k].delim = 1'b0;
    end
  end

  // a full output register blocks the next beat until the sink takes the row.
  assign in_ready = !out_valid || out_ready;
  assign in_fire  = in_valid && in_ready;
  assign row_done = &next_mask;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc_mask  <= '0;
      acc_delim <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (in_fire) begin
        acc_mask  <= row_done ? '0 : next_mask;
        acc_delim <= row_done ? 1'b0 : next_delim;
      end
      if (in_fire && row_done) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      acc_lane <= next_lane;
    end
    if (in_fire && row_done) begin
      out_row <= done_row;
    end
  end

endmodule

/* rtl/post_hash_pe_scheduler.sv */
`timescale 1ns/10ps

module post_hash_pe_scheduler (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      in_valid,
  input  post_hash_pkg::pe_beat_t   in_beat,
  output logic                      in_ready,

  output logic                      out_valid,
  output post_hash_pkg::issue_row_t out_row,
  input  logic                      out_ready
);

  logic                        merge_valid;
  post_hash_pkg::merged_beat_t merge_beat;
  logic                        merge_ready;

  logic                        xbar_valid;
  post_hash_pkg::row_beat_t    xbar_row;
  logic                        xbar_ready;

  hash_row_merge u_merge (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .in_ready  (in_ready),
    .out_valid (merge_valid),
    .out_beat  (merge_beat),
    .out_ready (merge_ready)
  );

  reorder_crossbar u_crossbar (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (merge_valid),
    .in_beat   (merge_beat),
    .in_ready  (merge_ready),
    .out_valid (xbar_valid),
    .out_row   (xbar_row),
    .out_ready (xbar_ready)
  );

  hash_row_synchronizer u_sync (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (xbar_valid),
    .in_row    (xbar_row),
    .in_ready  (xbar_ready),
    .out_valid (out_valid),
    .out_row   (out_row),
    .out_ready (out_ready)
  );

endmodule

/* test/sched_checker.sv */
`timescale 1ns/10ps

module sched_checker (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_valid,
  input  logic                      in_ready,
  input  logic                      out_valid,
  input  logic                      out_ready,
  input  post_hash_pkg::issue_row_t out_row,
  output int                        value_errors,
  output int                        other_errors,
  output int                        rows_seen,
  output logic                      saw_in_stall
);

  post_hash_pkg::issue_row_t exp_q[$];
  int                        need_q[$];
  int                        in_count;
  logic                      held_valid;
  post_hash_pkg::issue_row_t held_row;

  // last_beat is the number of input beats that must be accepted before the row may leave.
  task automatic expect_row(input post_hash_pkg::issue_row_t row, input int last_beat);
    exp_q.push_back(row);
    need_q.push_back(last_beat);
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      value_errors <= 0;
      other_errors <= 0;
      rows_seen    <= 0;
      in_count     <= 0;
      held_valid   <= 1'b0;
      saw_in_stall <= 1'b0;
    end else begin
      if (out_valid && out_ready && rows_seen < exp_q.size() && out_row !== exp_q[rows_seen]) begin
        $display("error: out_row %0d is %h, expected %h", rows_seen, out_row, exp_q[rows_seen]);
        value_errors <= value_errors + 1;
      end
      if (held_valid && (!out_valid || out_row !== held_row)) begin
        $display("the output row changed or vanished while out_ready was low");
        other_errors <= other_errors + 1;
      end else if (out_valid !== 1'b0 && in_count == 0) begin
        $display("out_valid was not low before any input beat was accepted");
        other_errors <= other_errors + 1;
      end else if (out_valid && out_ready && rows_seen >= exp_q.size()) begin
        $display("the DUT sent a row that no input window should have produced");
        other_errors <= other_errors + 1;
      end else if (out_valid && out_ready && in_count < need_q[rows_seen]) begin
        $display("row %0d left the DUT before its last input beat was accepted", rows_seen);
        other_errors <= other_errors + 1;
      end
      if (in_valid && in_ready) begin
        in_count <= in_count + 1;
      end
      if (out_valid && out_ready) begin
        rows_seen <= rows_seen + 1;
      end
      held_valid   <= out_valid && !out_ready;
      held_row     <= out_row;
      saw_in_stall <= saw_in_stall | (in_valid && !in_ready);
    end
  end

endmodule

/* test/tb_post_hash_pe_scheduler.sv */
`timescale 1ns/10ps

module tb_post_hash_pe_scheduler;

  localparam int clk_period = 100;
  localparam int num_stim   = 16;

  // lanes holds two bits per PE and cvalid holds one bit per candidate of each PE.
  typedef struct packed {
    logic [3:0]  mask;
    logic [15:0] base;
    logic [7:0]  lanes;
    logic [7:0]  cvalid;
    logic [3:0]  tie;
    logic [3:0]  delim;
    logic        stall;
  } stim_t;

  localparam stim_t stim_table [num_stim] = '{
    '{4'hf, 16'h0010, 8'he4, 8'hff, 4'h0, 4'h0, 1'b0},
    '{4'hf, 16'h0014, 8'h72, 8'h3d, 4'h6, 4'h0, 1'b0},
    '{4'h3, 16'h0018, 8'he4, 8'hfa, 4'h0, 4'h0, 1'b0},
    '{4'h1, 16'h0018, 8'he6, 8'hff, 4'h0, 4'h0, 1'b0},
    '{4'h1, 16'h0018, 8'he7, 8'hff, 4'h0, 4'h1, 1'b0},
    '{4'h5, 16'h001c, 8'h1b, 8'hff, 4'h0, 4'h0, 1'b0},
    '{4'ha, 16'h001c, 8'h1b, 8'hff, 4'h8, 4'h2, 1'b0},
    '{4'hf, 16'h0020, 8'h72, 8'hff, 4'h1, 4'h0, 1'b1},
    '{4'hf, 16'h0024, 8'h1b, 8'h7f, 4'h0, 4'h0, 1'b1},
    '{4'h3, 16'h0028, 8'he4, 8'hff, 4'h0, 4'h0, 1'b1},
    '{4'hc, 16'h0028, 8'he4, 8'hff, 4'h0, 4'h8, 1'b1},
    '{4'hf, 16'h002c, 8'he4, 8'hff, 4'h2, 4'h4, 1'b1},
    '{4'hf, 16'h0030, 8'h72, 8'hcf, 4'h0, 4'h0, 1'b1},
    '{4'hf, 16'h0034, 8'h1b, 8'hff, 4'h0, 4'h1, 1'b1},
    '{4'hf, 16'h0038, 8'he4, 8'hff, 4'h0, 4'h0, 1'b1},
    '{4'hf, 16'h003c, 8'h72, 8'hff, 4'h4, 4'h0, 1'b1}
  };

  logic                      clk;
  logic                      rst_n;
  logic                      in_valid;
  post_hash_pkg::pe_beat_t   in_beat;
  logic                      in_ready;
  logic                      out_valid;
  post_hash_pkg::issue_row_t out_row;
  logic                      out_ready = 1'b1;
  logic                      stall_mode;
  logic [31:0]               gen_lfsr = 32'h0c1b_500e;
  logic [31:0]               stall_lfsr = 32'h0c1b_500e;
  post_hash_pkg::pe_beat_t   beats [num_stim];
  int                        exp_total;
  int                        value_errors;
  int                        other_errors;
  int                        rows_seen;
  logic                      saw_in_stall;

  post_hash_pe_scheduler u_post_hash_pe_scheduler (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_row   (out_row),
    .out_ready (out_ready)
  );

  sched_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_row      (out_row),
    .value_errors (value_errors),
    .other_errors (other_errors),
    .rows_seen    (rows_seen),
    .saw_in_stall (saw_in_stall)
  );

  // one galois step where the bit shifted out is the bit taken.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int b = 0; b < n; b++) begin
      bits     = {bits[30:0], gen_lfsr[0]};
      gen_lfsr = lfsr_next(gen_lfsr);
    end
    return bits;
  endfunction

  // the first valid candidate is replaced only by a strictly longer one.
  function automatic post_hash_pkg::lane_t expected_lane(input post_hash_pkg::pe_result_t pe);
    post_hash_pkg::lane_t lane;
    int                   best;
    best = -1;
    for (int j = 0; j < post_hash_pkg::row_size; j++) begin
      if (pe.row[j].valid && (best < 0 || pe.row[j].meta_len > pe.row[best].meta_len)) begin
        best = j;
      end
    end
    lane      = '0;
    lane.data = pe.data;
    if (best >= 0) begin
      lane.hist_valid = 1'b1;
      lane.hist_addr  = pe.row[best].hist_addr;
      lane.meta_len   = pe.row[best].meta_len;
      lane.can_ext    = pe.row[best].can_ext;
    end
    return lane;
  endfunction

  task automatic build_tests();
    post_hash_pkg::issue_row_t exp_row;
    logic [3:0]                filled;
    logic [1:0]                lane_idx;
    exp_row   = '0;
    filled    = '0;
    exp_total = 0;
    for (int t = 0; t < num_stim; t++) begin
      beats[t].mask = stim_table[t].mask;
      for (int i = 0; i < post_hash_pkg::num_hash_pe; i++) begin
        lane_idx = stim_table[t].lanes[2*i +: 2];
        beats[t].pe[i].head_addr = stim_table[t].mask[i] ?
          {stim_table[t].base[15:2], lane_idx} : 16'(take_bits(16));
        for (int j = 0; j < post_hash_pkg::row_size; j++) begin
          beats[t].pe[i].row[j].valid     = stim_table[t].cvalid[2*i+j];
          beats[t].pe[i].row[j].hist_addr = 16'(take_bits(16));
          beats[t].pe[i].row[j].meta_len  = 5'(take_bits(5));
          beats[t].pe[i].row[j].can_ext   = 1'(take_bits(1));
        end
        if (stim_table[t].tie[i]) begin
          beats[t].pe[i].row[1].meta_len = beats[t].pe[i].row[0].meta_len;
        end
        beats[t].pe[i].delim = stim_table[t].delim[i];
        beats[t].pe[i].data  = 8'(take_bits(8));
        if (stim_table[t].mask[i]) begin
          exp_row.lane[lane_idx] = expected_lane(beats[t].pe[i]);
          exp_row.delim          = exp_row.delim | stim_table[t].delim[i];
          filled[lane_idx]       = 1'b1;
        end
      end
      if (&filled) begin
        exp_row.head_addr = stim_table[t].base;
        u_checker.expect_row(exp_row, t + 1);
        exp_total++;
        exp_row = '0;
        filled  = '0;
      end
    end
  endtask

  task automatic print_counts();
    $display("errors: %0d value, %0d protocol, %0d missing rows, %0d back-pressure",
             value_errors, other_errors,
             (rows_seen < exp_total) ? exp_total - rows_seen : 0,
             saw_in_stall ? 0 : 1);
  endtask

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // out_ready is random only while the current table row asks for stalls.
  always @(posedge clk) begin
    if (stall_mode) begin
      stall_lfsr <= lfsr_next(stall_lfsr);
      out_ready  <= stall_lfsr[0];
    end else begin
      out_ready  <= 1'b1;
    end
  end

  initial begin
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_beat    = '0;
    stall_mode = 1'b0;
    build_tests();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);
    for (int t = 0; t < num_stim; t++) begin
      in_valid   <= 1'b1;
      in_beat    <= beats[t];
      stall_mode <= stim_table[t].stall;
      @(posedge clk);
      while (!in_ready) @(posedge clk);
    end
    in_valid   <= 1'b0;
    stall_mode <= 1'b0;
    while (rows_seen < exp_total) @(posedge clk);
    repeat (10) @(posedge clk);
    if (!saw_in_stall) begin
      $display("in_ready never dropped under back-pressure while a beat was waiting");
    end
    print_counts();
    if (value_errors == 0 && other_errors == 0 && saw_in_stall) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #((num_stim + 20) * 8 * clk_period);
    $display("timeout: only %0d of %0d expected rows left the DUT", rows_seen, exp_total);
    print_counts();
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* post_hash_sched.f */
common/post_hash_pkg.sv
rtl/hash_row_merge.sv
rtl/reorder_crossbar.sv
rtl/hash_row_synchronizer.sv
rtl/post_hash_pe_scheduler.sv
test/sched_checker.sv
test/tb_post_hash_pe_scheduler.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_post_hash_pe_scheduler
FILELIST  ?= post_hash_sched.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
